//--- rtl/jesd_tx_defines.svh
/* JESD204B transmit link layer constants
   Lane count, beat width, 8b/10b control characters and ILAS sizes */
`ifndef JESD_TX_DEFINES_SVH
`define JESD_TX_DEFINES_SVH

// Link geometry
`define JESD_TX_NUM_LANES 2
`define JESD_TX_DPW 4

// ***************************************************************************
// Control characters as octet values

`define JESD_TX_K_R 8'h1c
`define JESD_TX_K_A 8'h7c
`define JESD_TX_K_Q 8'h9c
`define JESD_TX_K_K 8'hbc
`define JESD_TX_K_F 8'hfc

// Configuration words read during the second ILAS multiframe
`define JESD_TX_ILAS_CFG_WORDS 4

`endif

//--- rtl/jesd_tx_pkg.sv
/* JESD204B transmit link layer types
   Octet, beat, marker and counter types plus the link state encoding */
`include "jesd_tx_defines.svh"

package jesd_tx_pkg;

  typedef logic [7:0] octet_t;
  typedef logic [`JESD_TX_DPW*8-1:0] lane_beat_t;
  typedef logic [`JESD_TX_DPW-1:0] charisk_t;
  typedef logic [`JESD_TX_DPW-1:0] marker_t;
  typedef logic [5:0] beat_count_t;

  typedef enum logic [1:0] {
    ST_CGS  = 2'd0,
    ST_ILAS = 2'd1,
    ST_DATA = 2'd2
  } tx_state_t;

  // Index of the last beat in a multiframe
  // An octet count of 0 wraps to 63, which encodes K = 256
  function automatic beat_count_t last_beat(input octet_t octets_per_mf);
    return beat_count_t'((octets_per_mf >> $clog2(`JESD_TX_DPW)) - 8'd1);
  endfunction

endpackage

//--- rtl/jesd_tx_lmfc.sv
/* Local multiframe counter
   Counts beats per multiframe and aligns its phase to SYSREF edges */
`timescale 1ns/1ps

module jesd_tx_lmfc import jesd_tx_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_sysref,
  input  octet_t      i_cfg_octets_per_multiframe,
  input  beat_count_t i_cfg_lmfc_offset,
  input  logic        i_cfg_sysref_oneshot,
  output beat_count_t o_beat_count,
  output logic        o_lmfc_edge,
  output logic        o_sysref_edge,
  output logic        o_sysref_alignment_error
);

  beat_count_t beat_count;
  beat_count_t beat_count_next;
  logic        sysref_r;
  logic        sysref_d;
  logic        sysref_rise;
  logic        aligned;
  logic        realign;

  // Free running count, wraps after K/4 beats
  assign beat_count_next = (beat_count == last_beat(i_cfg_octets_per_multiframe)) ?
                           '0 : beat_count + beat_count_t'(1);

  assign sysref_rise = sysref_r & ~sysref_d;

  // Oneshot mode ignores every edge after the first one
  assign realign = sysref_rise & ~(i_cfg_sysref_oneshot & aligned);

  always_ff @(posedge clk) begin
    if (reset) begin
      sysref_r                 <= 1'b0;
      sysref_d                 <= 1'b0;
      beat_count               <= '0;
      aligned                  <= 1'b0;
      o_sysref_edge            <= 1'b0;
      o_sysref_alignment_error <= 1'b0;
    end else begin
      sysref_r      <= i_sysref;
      sysref_d      <= sysref_r;
      o_sysref_edge <= sysref_rise;
      // Out of phase if the free count would not land on the offset
      o_sysref_alignment_error <= sysref_rise & aligned &
                                  (beat_count_next != i_cfg_lmfc_offset);
      if (realign) begin
        beat_count <= i_cfg_lmfc_offset;
      end else begin
        beat_count <= beat_count_next;
      end
      if (sysref_rise) begin
        aligned <= 1'b1;
      end
    end
  end

  assign o_beat_count = beat_count;
  assign o_lmfc_edge  = (beat_count == '0);

endmodule

//--- rtl/jesd_tx_frame_mark.sv
/* Frame and multiframe marker generator
   Flags start and end of frame and multiframe for each octet of a beat */
`timescale 1ns/1ps
`include "jesd_tx_defines.svh"

module jesd_tx_frame_mark import jesd_tx_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  beat_count_t i_beat_count,
  input  octet_t      i_cfg_octets_per_frame,
  input  octet_t      i_cfg_octets_per_multiframe,
  output marker_t     o_sof,
  output marker_t     o_eof,
  output marker_t     o_somf,
  output marker_t     o_eomf
);

  octet_t      phase_r;
  octet_t      phase;
  octet_t      frame_last;
  beat_count_t mf_last;

  assign frame_last = i_cfg_octets_per_frame - 8'd1;
  assign mf_last    = last_beat(i_cfg_octets_per_multiframe);

  // Walk the frame phase across the octets of the beat
  always_comb begin
    phase = (i_beat_count == '0) ? '0 : phase_r;
    for (int j = 0; j < `JESD_TX_DPW; j++) begin
      o_sof[j]  = (phase == '0);
      o_eof[j]  = (phase == frame_last);
      o_somf[j] = (j == 0) && (i_beat_count == '0);
      o_eomf[j] = (j == `JESD_TX_DPW - 1) && (i_beat_count == mf_last);
      phase     = (phase == frame_last) ? '0 : phase + 8'd1;
    end
  end

  // Phase of the first octet of the next beat
  always_ff @(posedge clk) begin
    if (reset) begin
      phase_r <= '0;
    end else begin
      phase_r <= phase;
    end
  end

endmodule

//--- rtl/jesd_tx_ctrl.sv
/* Link controller for CGS, ILAS and DATA
   Builds the ILAS sequence and reads link configuration from memory */
`timescale 1ns/1ps
`include "jesd_tx_defines.svh"

module jesd_tx_ctrl import jesd_tx_pkg::*; (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_sync,
  input  logic                                i_lmfc_edge,
  input  beat_count_t                         i_beat_count,
  input  octet_t                              i_cfg_mframes_per_ilas,
  input  octet_t                              i_cfg_octets_per_multiframe,
  input  lane_beat_t [`JESD_TX_NUM_LANES-1:0] i_ilas_config_data,
  output tx_state_t                           o_state,
  output logic                                o_tx_ready,
  output lane_beat_t [`JESD_TX_NUM_LANES-1:0] o_ilas_data,
  output charisk_t   [`JESD_TX_NUM_LANES-1:0] o_ilas_charisk,
  output logic                                o_ilas_config_rd,
  output logic [1:0]                          o_ilas_config_addr
);

  tx_state_t state;
  tx_state_t state_next;
  logic      sync_meta;
  logic      sync_s;
  octet_t    mf_idx;
  logic      mf_end;
  logic      cfg_mf;
  logic      cfg_beat;
  octet_t    pos;

  assign mf_end   = (i_beat_count == last_beat(i_cfg_octets_per_multiframe));
  assign cfg_mf   = (mf_idx == 8'd1);
  assign cfg_beat = cfg_mf && (i_beat_count != '0) &&
                    (i_beat_count <= beat_count_t'(`JESD_TX_ILAS_CFG_WORDS));

  // ***************************************************************************
  // State machine, changes take effect on the lmfc edge

  always_comb begin
    state_next = state;
    if (mf_end) begin
      if (!sync_s) begin
        state_next = ST_CGS;
      end else begin
        case (state)
          ST_CGS:  state_next = ST_ILAS;
          ST_ILAS: begin
            if (mf_idx == i_cfg_mframes_per_ilas - 8'd1) begin
              state_next = ST_DATA;
            end
          end
          default: state_next = state;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_meta <= 1'b0;
      sync_s    <= 1'b0;
      state     <= ST_CGS;
      mf_idx    <= '0;
    end else begin
      sync_meta <= i_sync;
      sync_s    <= sync_meta;
      state     <= state_next;
      if (state != ST_ILAS) begin
        mf_idx <= '0;
      end else if (mf_end) begin
        mf_idx <= mf_idx + 8'd1;
      end
    end
  end

  // ***************************************************************************
  // ILAS beat generation

  // Memory answers one beat later, so read beats 0 to 3 for beats 1 to 4
  assign o_ilas_config_rd   = (state == ST_ILAS) && cfg_mf &&
                              (i_beat_count < beat_count_t'(`JESD_TX_ILAS_CFG_WORDS));
  assign o_ilas_config_addr = i_beat_count[1:0];

  always_comb begin
    pos = '0;
    for (int l = 0; l < `JESD_TX_NUM_LANES; l++) begin
      for (int j = 0; j < `JESD_TX_DPW; j++) begin
        pos = {i_beat_count, 2'(j)};
        o_ilas_data[l][j*8 +: 8] = pos;
        o_ilas_charisk[l][j]     = 1'b0;
        if (i_lmfc_edge && j == 0) begin
          o_ilas_data[l][j*8 +: 8] = `JESD_TX_K_R;
          o_ilas_charisk[l][j]     = 1'b1;
        end else if (mf_end && j == `JESD_TX_DPW - 1) begin
          o_ilas_data[l][j*8 +: 8] = `JESD_TX_K_A;
          o_ilas_charisk[l][j]     = 1'b1;
        end else if (cfg_mf && i_lmfc_edge && j == 1) begin
          o_ilas_data[l][j*8 +: 8] = `JESD_TX_K_Q;
          o_ilas_charisk[l][j]     = 1'b1;
        end else if (cfg_beat) begin
          o_ilas_data[l][j*8 +: 8] = i_ilas_config_data[l][j*8 +: 8];
        end
      end
    end
  end

  assign o_state    = state;
  assign o_tx_ready = (state == ST_DATA);

endmodule

//--- rtl/jesd_tx_lane.sv
/* Per-lane output stage
   Registers CGS, ILAS or data characters with end of frame replacement */
`timescale 1ns/1ps
`include "jesd_tx_defines.svh"

module jesd_tx_lane import jesd_tx_pkg::*; (
  input  logic       clk,
  input  tx_state_t  i_state,
  input  lane_beat_t i_ilas_data,
  input  charisk_t   i_ilas_charisk,
  input  lane_beat_t i_tx_data,
  input  marker_t    i_eof,
  input  marker_t    i_eomf,
  input  logic       i_cfg_disable_char_replacement,
  output lane_beat_t o_phy_data,
  output charisk_t   o_phy_charisk
);

  octet_t     last_eof_r;
  logic       last_eof_valid_r;
  octet_t     eof_octet;
  logic       eof_seen;
  lane_beat_t repl_data;
  charisk_t   repl_charisk;

  // ***************************************************************************
  // Character replacement

  // Compare against the previous end of frame octet, which may be in this beat
  always_comb begin
    eof_octet    = last_eof_r;
    eof_seen     = last_eof_valid_r;
    repl_data    = i_tx_data;
    repl_charisk = '0;
    for (int j = 0; j < `JESD_TX_DPW; j++) begin
      if (i_eof[j]) begin
        if (!i_cfg_disable_char_replacement && eof_seen &&
            i_tx_data[j*8 +: 8] == eof_octet) begin
          repl_data[j*8 +: 8] = i_eomf[j] ? `JESD_TX_K_A : `JESD_TX_K_F;
          repl_charisk[j]     = 1'b1;
        end
        // Original octet, not the replacement
        eof_octet = i_tx_data[j*8 +: 8];
        eof_seen  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_state == ST_DATA) begin
      last_eof_r       <= eof_octet;
      last_eof_valid_r <= eof_seen;
    end else begin
      last_eof_r       <= '0;
      last_eof_valid_r <= 1'b0;
    end
  end

  // Output register
  always_ff @(posedge clk) begin
    case (i_state)
      ST_ILAS: begin
        o_phy_data    <= i_ilas_data;
        o_phy_charisk <= i_ilas_charisk;
      end
      ST_DATA: begin
        o_phy_data    <= repl_data;
        o_phy_charisk <= repl_charisk;
      end
      default: begin
        o_phy_data    <= {`JESD_TX_DPW{`JESD_TX_K_K}};
        o_phy_charisk <= '1;
      end
    endcase
  end

endmodule

//--- rtl/jesd_tx_top.sv
/* JESD204B 8b/10b transmit link layer top level */
`timescale 1ns/1ps
`include "jesd_tx_defines.svh"

module jesd_tx_top import jesd_tx_pkg::*; (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_sysref,
  input  logic                                i_sync,
  input  octet_t                              i_cfg_octets_per_multiframe,
  input  octet_t                              i_cfg_octets_per_frame,
  input  octet_t                              i_cfg_mframes_per_ilas,
  input  beat_count_t                         i_cfg_lmfc_offset,
  input  logic                                i_cfg_sysref_oneshot,
  input  logic                                i_cfg_disable_char_replacement,
  input  lane_beat_t [`JESD_TX_NUM_LANES-1:0] i_tx_data,
  output logic                                o_tx_ready,
  output marker_t                             o_tx_sof,
  output marker_t                             o_tx_eof,
  output marker_t                             o_tx_somf,
  output marker_t                             o_tx_eomf,
  output lane_beat_t [`JESD_TX_NUM_LANES-1:0] o_phy_data,
  output charisk_t   [`JESD_TX_NUM_LANES-1:0] o_phy_charisk,
  output logic                                o_lmfc_edge,
  output logic                                o_sysref_edge,
  output logic                                o_sysref_alignment_error,
  output tx_state_t                           o_status_state,
  output logic                                o_ilas_config_rd,
  output logic [1:0]                          o_ilas_config_addr,
  input  lane_beat_t [`JESD_TX_NUM_LANES-1:0] i_ilas_config_data
);

  beat_count_t                         beat_count;
  lane_beat_t [`JESD_TX_NUM_LANES-1:0] ilas_data;
  charisk_t   [`JESD_TX_NUM_LANES-1:0] ilas_charisk;

  jesd_tx_lmfc u_lmfc (
    .clk                         (clk),
    .reset                       (reset),
    .i_sysref                    (i_sysref),
    .i_cfg_octets_per_multiframe (i_cfg_octets_per_multiframe),
    .i_cfg_lmfc_offset           (i_cfg_lmfc_offset),
    .i_cfg_sysref_oneshot        (i_cfg_sysref_oneshot),
    .o_beat_count                (beat_count),
    .o_lmfc_edge                 (o_lmfc_edge),
    .o_sysref_edge               (o_sysref_edge),
    .o_sysref_alignment_error    (o_sysref_alignment_error)
  );

  jesd_tx_frame_mark u_frame_mark (
    .clk                         (clk),
    .reset                       (reset),
    .i_beat_count                (beat_count),
    .i_cfg_octets_per_frame      (i_cfg_octets_per_frame),
    .i_cfg_octets_per_multiframe (i_cfg_octets_per_multiframe),
    .o_sof                       (o_tx_sof),
    .o_eof                       (o_tx_eof),
    .o_somf                      (o_tx_somf),
    .o_eomf                      (o_tx_eomf)
  );

  jesd_tx_ctrl u_ctrl (
    .clk                         (clk),
    .reset                       (reset),
    .i_sync                      (i_sync),
    .i_lmfc_edge                 (o_lmfc_edge),
    .i_beat_count                (beat_count),
    .i_cfg_mframes_per_ilas      (i_cfg_mframes_per_ilas),
    .i_cfg_octets_per_multiframe (i_cfg_octets_per_multiframe),
    .i_ilas_config_data          (i_ilas_config_data),
    .o_state                     (o_status_state),
    .o_tx_ready                  (o_tx_ready),
    .o_ilas_data                 (ilas_data),
    .o_ilas_charisk              (ilas_charisk),
    .o_ilas_config_rd            (o_ilas_config_rd),
    .o_ilas_config_addr          (o_ilas_config_addr)
  );

  // Markers of the sampling cycle travel with the data beat
  for (genvar l = 0; l < `JESD_TX_NUM_LANES; l++) begin : gen_lane
    jesd_tx_lane u_lane (
      .clk                            (clk),
      .i_state                        (o_status_state),
      .i_ilas_data                    (ilas_data[l]),
      .i_ilas_charisk                 (ilas_charisk[l]),
      .i_tx_data                      (i_tx_data[l]),
      .i_eof                          (o_tx_eof),
      .i_eomf                         (o_tx_eomf),
      .i_cfg_disable_char_replacement (i_cfg_disable_char_replacement),
      .o_phy_data                     (o_phy_data[l]),
      .o_phy_charisk                  (o_phy_charisk[l])
    );
  end

endmodule

//--- verification/tb_clock_gen.sv
/* Testbench clock source */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

//--- verification/jesd_tx_tb.sv
/* Testbench for the JESD204B transmit link layer
   Random traffic checked against a cycle model of CGS, ILAS, DATA and SYSREF */
`timescale 1ns/1ps
`include "jesd_tx_defines.svh"

module jesd_tx_tb import jesd_tx_pkg::*; ();

  localparam int NL          = `JESD_TX_NUM_LANES;
  localparam int DPW         = `JESD_TX_DPW;
  localparam int CLK_NS      = 4;
  localparam int BEATS       = 200;
  localparam int MAX_L       = 16;
  localparam int WATCHDOG_NS = 2 * 6 * (24 * MAX_L + 2 * BEATS) * CLK_NS;

  logic clk;
  logic reset;
  logic sysref;
  logic sync;
  logic oneshot;
  logic norepl;
  lane_beat_t [NL-1:0] tx_data;
  lane_beat_t [NL-1:0] cfg_data;
  lane_beat_t [NL-1:0] phy_data;
  charisk_t   [NL-1:0] phy_k;
  marker_t    sof, eof, somf, eomf;
  logic       tx_ready, lmfc_edge, sysref_edge, sysref_err, cfg_rd;
  logic [1:0] cfg_addr;
  tx_state_t  status;

  // Configuration and model state
  integer seed;
  int k_octets, f_octets, ilas_mfs, offset, beats_per_mf;
  int test_errors, tests_passed, tests_failed;
  int ilas_cycles, err_pulses, repl_count;
  lane_beat_t [NL-1:0] mem [4];
  lane_beat_t [NL-1:0] exp_data;
  charisk_t   [NL-1:0] exp_k;
  octet_t     last_eof [NL];
  octet_t     rep_octet [NL];
  logic [NL-1:0] last_valid;
  logic       repeat_mode, rd_pend, exp_sref_edge, exp_sref_err;
  logic [1:0] rd_addr;
  int         m_bc, m_mf;
  tx_state_t  m_state;
  logic       m_sync1, m_sync2, m_sref1, m_sref2, m_aligned;

  tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clock (.o_clk(clk));

  jesd_tx_top UUT (
    .clk                            (clk),
    .reset                          (reset),
    .i_sysref                       (sysref),
    .i_sync                         (sync),
    .i_cfg_octets_per_multiframe    (octet_t'(k_octets)),
    .i_cfg_octets_per_frame         (octet_t'(f_octets)),
    .i_cfg_mframes_per_ilas         (octet_t'(ilas_mfs)),
    .i_cfg_lmfc_offset              (beat_count_t'(offset)),
    .i_cfg_sysref_oneshot           (oneshot),
    .i_cfg_disable_char_replacement (norepl),
    .i_tx_data                      (tx_data),
    .o_tx_ready                     (tx_ready),
    .o_tx_sof                       (sof),
    .o_tx_eof                       (eof),
    .o_tx_somf                      (somf),
    .o_tx_eomf                      (eomf),
    .o_phy_data                     (phy_data),
    .o_phy_charisk                  (phy_k),
    .o_lmfc_edge                    (lmfc_edge),
    .o_sysref_edge                  (sysref_edge),
    .o_sysref_alignment_error       (sysref_err),
    .o_status_state                 (status),
    .o_ilas_config_rd               (cfg_rd),
    .o_ilas_config_addr             (cfg_addr),
    .i_ilas_config_data             (cfg_data)
  );

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    if (exp_v !== got_v) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
      test_errors++;
    end
  endtask

  // ***************************************************************************
  // Check outputs, drive inputs and advance the model by one cycle

  task automatic step();
    int        p;
    int        free_bc;
    logic      rise;
    logic      hit;
    logic      exp_rd;
    octet_t    oct;
    tx_state_t nxt;
    marker_t   e_sof, e_eof, e_somf, e_eomf;
    for (int l = 0; l < NL; l++) begin
      check_val($sformatf("o_phy_data[%0d]", l), 32'(exp_data[l]), 32'(phy_data[l]));
      check_val($sformatf("o_phy_charisk[%0d]", l), 32'(exp_k[l]), 32'(phy_k[l]));
    end
    for (int j = 0; j < DPW; j++) begin
      p         = 4 * m_bc + j;
      e_sof[j]  = (p % f_octets == 0);
      e_eof[j]  = (p % f_octets == f_octets - 1);
      e_somf[j] = (p == 0);
      e_eomf[j] = (p == k_octets - 1);
    end
    exp_rd = (m_state == ST_ILAS) && (m_mf == 1) && (m_bc < `JESD_TX_ILAS_CFG_WORDS);
    check_val("o_tx_sof", 32'(e_sof), 32'(sof));
    check_val("o_tx_eof", 32'(e_eof), 32'(eof));
    check_val("o_tx_somf", 32'(e_somf), 32'(somf));
    check_val("o_tx_eomf", 32'(e_eomf), 32'(eomf));
    check_val("o_lmfc_edge", 32'(m_bc == 0), 32'(lmfc_edge));
    check_val("o_sysref_edge", 32'(exp_sref_edge), 32'(sysref_edge));
    check_val("o_sysref_alignment_error", 32'(exp_sref_err), 32'(sysref_err));
    check_val("o_status_state", 32'(m_state), 32'(status));
    check_val("o_tx_ready", 32'(m_state == ST_DATA), 32'(tx_ready));
    check_val("o_ilas_config_rd", 32'(exp_rd), 32'(cfg_rd));
    if (exp_rd) begin
      check_val("o_ilas_config_addr", 32'(m_bc), 32'(cfg_addr));
    end
    if (status == ST_ILAS) begin
      ilas_cycles++;
    end
    if (sysref_err) begin
      err_pulses++;
    end
    // Configuration memory answers one cycle after the read
    cfg_data = rd_pend ? mem[rd_addr] : {$random(seed), $random(seed)};
    rd_pend  = cfg_rd;
    rd_addr  = cfg_addr;
    for (int l = 0; l < NL; l++) begin
      if (m_state != ST_DATA) begin
        last_valid[l] = 1'b0;
      end
      for (int j = 0; j < DPW; j++) begin
        if (repeat_mode && ($random(seed) & 1)) begin
          tx_data[l][j*8 +: 8] = rep_octet[l];
        end else begin
          tx_data[l][j*8 +: 8] = octet_t'($random(seed));
        end
        p           = 4 * m_bc + j;
        oct         = `JESD_TX_K_K;
        exp_k[l][j] = 1'b1;
        if (m_state == ST_ILAS) begin
          oct = octet_t'(p);
          exp_k[l][j] = 1'b0;
          if (p == 0) begin
            oct = `JESD_TX_K_R;
            exp_k[l][j] = 1'b1;
          end else if (p == k_octets - 1) begin
            oct = `JESD_TX_K_A;
            exp_k[l][j] = 1'b1;
          end else if (m_mf == 1 && p == 1) begin
            oct = `JESD_TX_K_Q;
            exp_k[l][j] = 1'b1;
          end else if (m_mf == 1 && m_bc >= 1 && m_bc <= `JESD_TX_ILAS_CFG_WORDS) begin
            oct = mem[2'(m_bc - 1)][l][j*8 +: 8];
          end
        end else if (m_state == ST_DATA) begin
          oct = tx_data[l][j*8 +: 8];
          exp_k[l][j] = 1'b0;
          if (p % f_octets == f_octets - 1) begin
            hit           = !norepl && last_valid[l] && (oct == last_eof[l]);
            last_eof[l]   = oct;
            last_valid[l] = 1'b1;
            if (hit) begin
              oct = (p == k_octets - 1) ? `JESD_TX_K_A : `JESD_TX_K_F;
              exp_k[l][j] = 1'b1;
              repl_count++;
            end
          end
        end
        exp_data[l][j*8 +: 8] = oct;
      end
    end
    // Link state changes at the end of a multiframe
    nxt = m_state;
    if (m_bc == beats_per_mf - 1) begin
      if (!m_sync2) begin
        nxt = ST_CGS;
      end else if (m_state == ST_CGS) begin
        nxt = ST_ILAS;
      end else if (m_state == ST_ILAS && m_mf == ilas_mfs - 1) begin
        nxt = ST_DATA;
      end
    end
    if (m_state != ST_ILAS) begin
      m_mf = 0;
    end else if (m_bc == beats_per_mf - 1) begin
      m_mf++;
    end
    m_state = nxt;
    m_sync2 = m_sync1;
    m_sync1 = sync;
    // Count lands on the offset the cycle after the SYSREF register shows a rise
    rise          = m_sref1 && !m_sref2;
    free_bc       = (m_bc == beats_per_mf - 1) ? 0 : m_bc + 1;
    exp_sref_edge = rise;
    exp_sref_err  = rise && m_aligned && (free_bc != offset);
    m_bc          = (rise && !(oneshot && m_aligned)) ? offset : free_bc;
    m_aligned     = m_aligned | rise;
    m_sref2       = m_sref1;
    m_sref1       = sysref;
    @(negedge clk);
  endtask

  task automatic randomize_config();
    int sel;
    sel          = $unsigned($random(seed)) % 3;
    f_octets     = (sel == 2) ? 4 : sel + 1;
    k_octets     = 24 + 4 * ($unsigned($random(seed)) % 11);
    beats_per_mf = k_octets / 4;
    ilas_mfs     = 2 + $unsigned($random(seed)) % 3;
    offset       = $unsigned($random(seed)) % beats_per_mf;
    for (int l = 0; l < NL; l++) begin
      rep_octet[l] = octet_t'($random(seed));
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset  = 1'b1;
    sysref = 1'b0;
    sync   = 1'b0;
    repeat (5) @(negedge clk);
    reset         = 1'b0;
    m_bc          = 0;
    m_mf          = 0;
    m_state       = ST_CGS;
    m_sync1       = 1'b0;
    m_sync2       = 1'b0;
    m_sref1       = 1'b0;
    m_sref2       = 1'b0;
    m_aligned     = 1'b0;
    exp_sref_edge = 1'b0;
    exp_sref_err  = 1'b0;
    rd_pend       = 1'b0;
    last_valid    = '0;
    exp_data      = {NL*DPW{`JESD_TX_K_K}};
    exp_k         = '1;
  endtask

  task automatic bring_up();
    int n;
    n           = 0;
    ilas_cycles = 0;
    sync        = 1'b1;
    while (!tx_ready && n < 8 * beats_per_mf) begin
      step();
      n++;
    end
    if (!tx_ready) begin
      $display("Link did not reach DATA within %0d cycles", n);
      test_errors++;
    end else if (ilas_cycles != ilas_mfs * beats_per_mf) begin
      $display("ILAS lasted %0d cycles instead of %0d", ilas_cycles, ilas_mfs * beats_per_mf);
      test_errors++;
    end
  endtask

  // High for two cycles and low until the next pulse starts
  task automatic pulse_sysref(input int gap);
    sysref = 1'b1;
    step();
    step();
    sysref = 1'b0;
    repeat (gap - 2) step();
  endtask

  task automatic run_link(input logic no_repl, input logic rep, input int beats);
    randomize_config();
    norepl      = no_repl;
    repeat_mode = rep;
    repl_count  = 0;
    apply_reset();
    repeat (2 * beats_per_mf) step();
    bring_up();
    repeat (beats) step();
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // ***************************************************************************
  // Test sequence

  initial begin
    int n;
    seed = 96324;
    reset = 1'b1;
    sysref = 1'b0;
    sync = 1'b0;
    oneshot = 1'b0;
    norepl = 1'b1;
    repeat_mode = 1'b0;
    tx_data = '0;
    cfg_data = '0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    randomize_config();
    for (int a = 0; a < 4; a++) begin
      mem[a] = {$random(seed), $random(seed)};
    end

    randomize_config();
    apply_reset();
    repeat (3 * beats_per_mf) step();
    end_test("CGS after reset");

    // Aligning edge, an in-phase edge, then one edge a beat out of phase
    for (int os = 0; os < 2; os++) begin
      randomize_config();
      oneshot = (os == 1);
      apply_reset();
      err_pulses = 0;
      pulse_sysref(2 * beats_per_mf);
      pulse_sysref(2 * beats_per_mf + 1);
      pulse_sysref(2 * beats_per_mf);
      repeat (2 * beats_per_mf) step();
      if (err_pulses != 1) begin
        $display("Expected one SYSREF alignment error pulse, saw %0d", err_pulses);
        test_errors++;
      end
    end
    oneshot = 1'b0;
    end_test("SYSREF alignment");

    run_link(1'b1, 1'b0, 0);
    end_test("ILAS sequence");

    run_link(1'b1, 1'b0, BEATS);
    end_test("DATA pass-through");

    run_link(1'b0, 1'b1, BEATS);
    if (repl_count == 0) begin
      $display("No character replacement was provoked");
      test_errors++;
    end
    end_test("Character replacement");

    run_link(1'($random(seed)), 1'b0, BEATS / 4);
    sync = 1'b0;
    n = 0;
    while (tx_ready && n < 3 * beats_per_mf) begin
      step();
      n++;
    end
    if (tx_ready) begin
      $display("Ready stayed high %0d cycles after sync loss", n);
      test_errors++;
    end
    repeat (2 * beats_per_mf) step();
    bring_up();
    repeat (BEATS / 4) step();
    end_test("Sync loss");

    $display("%0d of %0d tests ok, %0d failing", tests_passed, tests_passed + tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

//--- src.f
+incdir+rtl
rtl/jesd_tx_pkg.sv
rtl/jesd_tx_lmfc.sv
rtl/jesd_tx_frame_mark.sv
rtl/jesd_tx_ctrl.sv
rtl/jesd_tx_lane.sv
rtl/jesd_tx_top.sv
verification/tb_clock_gen.sv
verification/jesd_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the JESD204B transmit link layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module jesd_tx_tb -Mdir obj_dir -o jesd_tx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/jesd_tx_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1
